// File: axis_rx_stage.sv
`timescale 1ns/100ps
// --------------------
// one-word data delay and the registered
// stream outputs
// --------------------
module axis_rx_stage (
    input  logic                      clk,
    input  logic                      inv_aresetn,
    input  xgmii_rx_pkg::xgmii_data_t xgmii_d_i,
    input  logic                      beat_hold_i,
    input  logic                      beat_valid_i,
    input  logic                      beat_last_i,
    input  xgmii_rx_pkg::keep_t       beat_keep_i,
    input  logic                      beat_good_i,
    output xgmii_rx_pkg::xgmii_data_t tdata_o,
    output xgmii_rx_pkg::keep_t       tkeep_o,
    output logic                      tvalid_o,
    output logic                      tlast_o,
    output logic                      tuser_o
);
    import xgmii_rx_pkg::*;

    xgmii_data_t d_q;
    xgmii_data_t beat_data;

    // delay line
    always_ff @(posedge clk) begin
        d_q <= xgmii_d_i;
    end

    assign beat_data = beat_hold_i ? d_q : xgmii_d_i;

    // --------------------
    // output beat
    // --------------------
    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            tvalid_o <= 1'b0;
            tlast_o  <= 1'b0;
            tuser_o  <= 1'b0;
        end else begin
            tvalid_o <= beat_valid_i;
            tlast_o  <= beat_valid_i && beat_last_i;
            // good bit only ever on a last beat
            tuser_o  <= beat_valid_i && beat_last_i && beat_good_i;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            tdata_o <= beat_data;
            tkeep_o <= beat_keep_i;
        end
    end

endmodule

// File: list.f
+incdir+.
xgmii_rx_pkg.sv
xgmii_term_decode.sv
xgmii_crc_engine.sv
xgmii_rx_fsm.sv
axis_rx_stage.sv
rx_frame_counter.sv
xgmii_rx_top.sv
tb_xgmii_rx.sv

// File: rx_frame_counter.sv
`timescale 1ns/100ps
// --------------------
// good and bad frame counters
// --------------------
module rx_frame_counter #(
    parameter int STAT_W = 32
) (
    input  logic              clk,
    input  logic              inv_aresetn,
    input  logic              tvalid_i,
    input  logic              tlast_i,
    input  logic              tuser_i,
    output logic [STAT_W-1:0] good_frames_o,
    output logic [STAT_W-1:0] bad_frames_o
);

    // one count per last beat, sorted by the good bit
    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            good_frames_o <= '0;
            bad_frames_o  <= '0;
        end else if (tvalid_i && tlast_i) begin
            if (tuser_i) begin
                good_frames_o <= good_frames_o + 1'b1;
            end else begin
                bad_frames_o <= bad_frames_o + 1'b1;
            end
        end
    end

endmodule

// File: tb_xgmii_model.svh
// --------------------
// testbench model: xorshift source, reference crc-32,
// frame builder, stimulus and expected-beat queues
// --------------------
`ifndef TB_XGMII_MODEL_SVH
`define TB_XGMII_MODEL_SVH

    logic [31:0] rng_state = 32'ha98b;
    logic [7:0]  frame_q[$];
    logic [63:0] stim_d_q[$];
    logic [7:0]  stim_c_q[$];
    logic [63:0] exp_data_q[$];
    logic [7:0]  exp_keep_q[$];
    logic        exp_last_q[$];
    logic        exp_user_q[$];
    int          exp_good_cnt = 0;
    int          exp_bad_cnt  = 0;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // reflected crc-32 with final complement, over frame_q[0..n-1]
    function automatic logic [31:0] ref_fcs(int n);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            c = c ^ {24'h0, frame_q[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic push_beat(logic [63:0] d, logic [7:0] k, logic l, logic u);
        exp_data_q.push_back(d);
        exp_keep_q.push_back(k);
        exp_last_q.push_back(l);
        exp_user_q.push_back(u);
    endtask

    task automatic push_word(logic [63:0] d, logic [7:0] c);
        stim_d_q.push_back(d);
        stim_c_q.push_back(c);
    endtask

    // --------------------
    // frame builder
    // --------------------
    // kind 0..4 good, 5 fcs byte flipped, 6 bad terminate byte, 7 abort
    task automatic build_frame(int idx);
        logic [31:0] r;
        logic [31:0] fcs;
        logic [63:0] w;
        logic [7:0]  m;
        logic [7:0]  tchar;
        int          kind;
        int          lane;
        int          words;
        int          nbytes;
        int          cnt;
        int          nbeats;
        int          p;
        frame_q.delete();
        push_word({PREAMBLE_TAIL, XGMII_START}, 8'h01);
        r    = next_rand();
        kind = int'(r % 8);
        if (kind == 7) begin
            r     = next_rand();
            words = 2 + int'(r % 10);
            for (int wi = 0; wi < words; wi++) begin
                w = {next_rand(), next_rand()};
                push_word(w, 8'h00);
                push_beat(w, 8'hFF, wi == words - 1, 1'b0);
            end
            // lane 0 set with lane 7 clear is never data or terminate
            r = next_rand();
            m = (r[7:0] | 8'h01) & 8'h7F;
            push_word({next_rand(), r}, m);
            exp_bad_cnt++;
        end else begin
            // terminate lane walks through all eight positions
            lane   = idx % 8;
            r      = next_rand();
            words  = 3 + int'(r % 9);
            nbytes = 8 * words + lane;
            for (int i = 0; i < nbytes - 4; i++) begin
                r = next_rand();
                frame_q.push_back(r[7:0]);
            end
            fcs = ref_fcs(nbytes - 4);
            for (int i = 0; i < 4; i++) begin
                frame_q.push_back(fcs[8*i +: 8]);
            end
            r = next_rand();
            if (kind == 5) begin
                p          = nbytes - 4 + int'(r % 4);
                frame_q[p] = frame_q[p] ^ {r[14:8], 1'b1};
            end
            tchar = XGMII_TERM;
            if (kind == 6) begin
                tchar = (r[23:16] == XGMII_TERM) ? XGMII_IDLE : r[23:16];
            end
            for (int wi = 0; wi < words; wi++) begin
                for (int j = 0; j < 8; j++) begin
                    w[8*j +: 8] = frame_q[8*wi + j];
                end
                push_word(w, 8'h00);
            end
            for (int j = 0; j < 8; j++) begin
                if (j < lane) begin
                    w[8*j +: 8] = frame_q[8*words + j];
                end else if (j == lane) begin
                    w[8*j +: 8] = tchar;
                end else begin
                    w[8*j +: 8] = XGMII_IDLE;
                end
            end
            m = 8'hFF << lane;
            push_word(w, m);
            // beats carry the frame bytes without the fcs
            nbeats = (nbytes - 4 + 7) / 8;
            for (int b = 0; b < nbeats; b++) begin
                cnt = nbytes - 4 - 8 * b;
                if (cnt > 8) begin
                    cnt = 8;
                end
                w = '0;
                for (int j = 0; j < cnt; j++) begin
                    w[8*j +: 8] = frame_q[8*b + j];
                end
                push_beat(w, 8'hFF >> (8 - cnt), b == nbeats - 1,
                          (b == nbeats - 1) && (kind < 5));
            end
            if (kind < 5) begin
                exp_good_cnt++;
            end else begin
                exp_bad_cnt++;
            end
        end
        // idle gap of 1..MAX_GAP words
        r = next_rand();
        for (int g = 0; g <= int'(r % MAX_GAP); g++) begin
            push_word({8{XGMII_IDLE}}, 8'hFF);
        end
    endtask

`endif

// File: tb_xgmii_rx.sv
`timescale 1ns/100ps
// --------------------
// testbench for the xgmii receive adapter
// random frames, in-order beat checks, frame counter check
// --------------------
module tb_xgmii_rx;
    import xgmii_rx_pkg::*;

    localparam int NUM_FRAMES = 96;
    localparam int MAX_GAP    = 6;
    localparam int MAX_CYCLES = NUM_FRAMES * (14 + MAX_GAP) + 100;

    logic        clk = 1'b0;
    logic        inv_aresetn;
    logic [63:0] xgmii_d;
    logic [7:0]  xgmii_c;
    logic [63:0] tdata;
    logic [7:0]  tkeep;
    logic        tvalid;
    logic        tlast;
    logic        tuser;
    logic [31:0] good_frames;
    logic [31:0] bad_frames;
    int          value_errs = 0;
    int          other_errs = 0;
    int          cycle_cnt  = 0;

    `include "tb_xgmii_model.svh"

    always #10 clk = ~clk;

    xgmii_rx_top #(
        .STAT_W (32)
    ) u_dut (
        .clk           (clk),
        .inv_aresetn   (inv_aresetn),
        .xgmii_d_i     (xgmii_d),
        .xgmii_c_i     (xgmii_c),
        .tdata_o       (tdata),
        .tkeep_o       (tkeep),
        .tvalid_o      (tvalid),
        .tlast_o       (tlast),
        .tuser_o       (tuser),
        .good_frames_o (good_frames),
        .bad_frames_o  (bad_frames)
    );

    // byte enables widened to a bit mask
    function automatic logic [63:0] keep_mask(logic [7:0] k);
        logic [63:0] bm;
        for (int j = 0; j < 8; j++) begin
            bm[8*j +: 8] = {8{k[j]}};
        end
        return bm;
    endfunction

    // --------------------
    // beat checker
    // --------------------
    task automatic check_beat();
        logic [63:0] ed;
        logic [7:0]  ek;
        logic        el;
        logic        eu;
        logic [63:0] bm;
        assert (exp_data_q.size() > 0) else begin
            $display("a beat arrived that the model did not expect");
            other_errs++;
        end
        if (exp_data_q.size() > 0) begin
            ed = exp_data_q.pop_front();
            ek = exp_keep_q.pop_front();
            el = exp_last_q.pop_front();
            eu = exp_user_q.pop_front();
            bm = keep_mask(ek);
            assert ((tdata & bm) === (ed & bm)) else begin
                $display("Fail tdata_o: expected %h, got %h", ed & bm, tdata & bm);
                value_errs++;
            end
            assert (tkeep === ek) else begin
                $display("Fail tkeep_o: expected %h, got %h", ek, tkeep);
                value_errs++;
            end
            assert (tlast === el) else begin
                $display("Fail tlast_o: expected %h, got %h", el, tlast);
                value_errs++;
            end
            assert (tuser === eu) else begin
                $display("Fail tuser_o: expected %h, got %h", eu, tuser);
                value_errs++;
            end
        end
    endtask

    // outputs settle after the rising edge, sample on the falling one
    always @(negedge clk) begin
        if (!inv_aresetn && tvalid) begin
            check_beat();
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // --------------------
    // stimulus and final checks
    // --------------------
    initial begin
        inv_aresetn = 1'b1;
        xgmii_d     = {8{XGMII_IDLE}};
        xgmii_c     = 8'hFF;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            build_frame(i);
        end
        repeat (3) @(posedge clk);
        inv_aresetn <= 1'b0;
        @(negedge clk);
        assert (tvalid === 1'b0) else begin
            $display("Fail tvalid_o: expected %h, got %h", 1'b0, tvalid);
            value_errs++;
        end
        assert (good_frames === 32'h0 && bad_frames === 32'h0) else begin
            $display("Fail good_frames_o/bad_frames_o: expected 0/0, got %h/%h",
                     good_frames, bad_frames);
            value_errs++;
        end
        while (stim_d_q.size() > 0) begin
            @(posedge clk);
            xgmii_d <= stim_d_q.pop_front();
            xgmii_c <= stim_c_q.pop_front();
        end
        // trailing idle, the last word driven is already idle
        repeat (10) @(posedge clk);
        @(negedge clk);
        assert (exp_data_q.size() == 0) else begin
            $display("%0d expected beats never came out", exp_data_q.size());
            other_errs++;
        end
        assert (good_frames === 32'(exp_good_cnt)) else begin
            $display("Fail good_frames_o: expected %h, got %h", 32'(exp_good_cnt), good_frames);
            value_errs++;
        end
        assert (bad_frames === 32'(exp_bad_cnt)) else begin
            $display("Fail bad_frames_o: expected %h, got %h", 32'(exp_bad_cnt), bad_frames);
            value_errs++;
        end
        $display("frames %0d, value errors %0d, other errors %0d",
                 NUM_FRAMES, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: xgmii_crc_engine.sv
`timescale 1ns/100ps
// --------------------
// running crc-32 over the frame bytes, partial crcs
// for the short endings and the fcs comparison
// --------------------
module xgmii_crc_engine (
    input  logic                      clk,
    input  logic                      inv_aresetn,
    input  xgmii_rx_pkg::xgmii_data_t data_i,
    input  logic                      clear_i,
    input  logic                      advance_i,
    input  logic                      term_i,
    input  xgmii_rx_pkg::lane_t       term_lane_i,
    input  logic                      fin_i,
    output logic                      fcs_ok_o
);
    import xgmii_rx_pkg::*;

    crc_t        crc_q;
    crc_t        crc4_q;
    crc_t        crc5_q;
    crc_t        crc6_q;
    crc_t        crc7_q;
    xgmii_data_t prev_q;
    crc_t        fin_crc_q;
    crc_t        fin_fcs_q;
    crc_t        rx_fcs;
    crc_t        part_crc;
    logic        term_ok;

    // --------------------
    // running crc
    // --------------------
    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            crc_q <= CRC_PRESET;
        end else if (clear_i) begin
            crc_q <= CRC_PRESET;
        end else if (advance_i) begin
            crc_q <= crc_bytes(crc_q, data_i, 8);
        end
    end

    // partial crcs of the word just taken, for fcs split across words
    always_ff @(posedge clk) begin
        prev_q <= data_i;
        if (advance_i) begin
            crc4_q <= crc_bytes(crc_q, data_i, 4);
            crc5_q <= crc_bytes(crc_q, data_i, 5);
            crc6_q <= crc_bytes(crc_q, data_i, 6);
            crc7_q <= crc_bytes(crc_q, data_i, 7);
        end
    end

    // --------------------
    // terminate in lanes 0..4
    // --------------------
    // fcs starts in the previous word
    always_comb begin
        case (term_lane_i)
            3'd0: begin
                rx_fcs   = prev_q[63:32];
                part_crc = crc4_q;
            end
            3'd1: begin
                rx_fcs   = {data_i[7:0], prev_q[63:40]};
                part_crc = crc5_q;
            end
            3'd2: begin
                rx_fcs   = {data_i[15:0], prev_q[63:48]};
                part_crc = crc6_q;
            end
            3'd3: begin
                rx_fcs   = {data_i[23:0], prev_q[63:56]};
                part_crc = crc7_q;
            end
            default: begin
                rx_fcs   = data_i[31:0];
                part_crc = crc_q;
            end
        endcase
    end

    assign term_ok = (fcs_of(part_crc) == rx_fcs);

    // --------------------
    // terminate in lanes 5..7
    // --------------------
    // finish crc over the 1..3 data bytes, compare one cycle later
    always_ff @(posedge clk) begin
        if (term_i) begin
            fin_crc_q <= crc_bytes(crc_q, data_i, int'(term_lane_i) - 4);
            case (term_lane_i)
                3'd5:    fin_fcs_q <= data_i[39:8];
                3'd6:    fin_fcs_q <= data_i[47:16];
                default: fin_fcs_q <= data_i[55:24];
            endcase
        end
    end

    assign fcs_ok_o = fin_i ? (fcs_of(fin_crc_q) == fin_fcs_q) : (term_i && term_ok);

endmodule

// File: xgmii_rx_fsm.sv
`timescale 1ns/100ps
// --------------------
// frame state machine: idle, data, fin
// drives crc strobes and the output beat controls
// --------------------
module xgmii_rx_fsm (
    input  logic                clk,
    input  logic                inv_aresetn,
    input  logic                sof_i,
    input  logic                data_word_i,
    input  logic                term_i,
    input  xgmii_rx_pkg::lane_t term_lane_i,
    input  logic                term_char_ok_i,
    input  logic                bad_ctrl_i,
    input  logic                fcs_ok_i,
    output logic                crc_clear_o,
    output logic                crc_advance_o,
    output logic                crc_fin_o,
    output logic                beat_valid_o,
    output logic                beat_last_o,
    output xgmii_rx_pkg::keep_t beat_keep_o,
    output logic                beat_good_o,
    output logic                beat_hold_o
);
    import xgmii_rx_pkg::*;

    rx_state_e state_q;
    rx_state_e state_d;
    logic      have_prev_q;
    keep_t     fin_keep_q;
    logic      fin_tchar_q;
    logic      late_term;
    keep_t     term_keep;
    keep_t     late_keep;

    // fcs reaching into the terminate word, lanes 5..7
    assign late_term = term_lane_i[2] && (term_lane_i[1:0] != 2'd0);

    // L=0..4 keeps 4+L bytes of the previous word
    assign term_keep = keep_t'(8'hFF >> (4 - int'(term_lane_i)));
    // L=5..7 keeps L-4 bytes of the terminate word
    assign late_keep = keep_t'(8'hFF >> (12 - int'(term_lane_i)));

    // --------------------
    // state and flags
    // --------------------
    always_ff @(posedge clk) begin
        if (inv_aresetn) begin
            state_q     <= IDLE;
            have_prev_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            // first data cycle has only the start word behind it
            have_prev_q <= (state_q == DATA);
        end
    end

    // ending details kept for the fin cycle
    always_ff @(posedge clk) begin
        if (term_i) begin
            fin_keep_q  <= late_keep;
            fin_tchar_q <= term_char_ok_i;
        end
    end

    // --------------------
    // next state and beats
    // --------------------
    always_comb begin
        state_d       = state_q;
        crc_clear_o   = 1'b0;
        crc_advance_o = 1'b0;
        crc_fin_o     = 1'b0;
        beat_valid_o  = 1'b0;
        beat_last_o   = 1'b0;
        beat_keep_o   = 8'hFF;
        beat_good_o   = 1'b0;
        beat_hold_o   = 1'b0;
        case (state_q)
            IDLE: begin
                if (sof_i) begin
                    crc_clear_o = 1'b1;
                    state_d     = DATA;
                end
            end
            DATA: begin
                // beats always come from the word before the current one
                beat_hold_o = 1'b1;
                if (data_word_i) begin
                    crc_advance_o = 1'b1;
                    beat_valid_o  = have_prev_q;
                end else if (term_i && !late_term) begin
                    beat_valid_o = have_prev_q;
                    beat_last_o  = 1'b1;
                    beat_keep_o  = term_keep;
                    beat_good_o  = fcs_ok_i && term_char_ok_i;
                    state_d      = IDLE;
                end else if (term_i) begin
                    // full beat now, the short tail follows in fin
                    beat_valid_o = have_prev_q;
                    state_d      = FIN;
                end else if (bad_ctrl_i) begin
                    // abort, close on the last whole data word
                    beat_valid_o = have_prev_q;
                    beat_last_o  = 1'b1;
                    state_d      = IDLE;
                end
            end
            FIN: begin
                beat_hold_o  = 1'b1;
                crc_fin_o    = 1'b1;
                beat_valid_o = 1'b1;
                beat_last_o  = 1'b1;
                beat_keep_o  = fin_keep_q;
                beat_good_o  = fcs_ok_i && fin_tchar_q;
                state_d      = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

endmodule

// File: xgmii_rx_pkg.sv
// --------------------
// shared definitions for the xgmii receive path
// widths, control characters, crc helpers, frame states
// --------------------
package xgmii_rx_pkg;

    localparam int DATA_W = 64;
    localparam int CTRL_W = 8;

    typedef logic [DATA_W-1:0] xgmii_data_t;
    typedef logic [CTRL_W-1:0] xgmii_ctrl_t;
    typedef logic [CTRL_W-1:0] keep_t;
    typedef logic [2:0]        lane_t;
    typedef logic [31:0]       crc_t;

    // --------------------
    // xgmii control characters
    // --------------------
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_IDLE  = 8'h07;

    // lanes 1 to 7 of a lane-0 start word, sfd sits in lane 7
    localparam logic [55:0] PREAMBLE_TAIL = 56'hD5_5555_5555_5555;

    // --------------------
    // crc-32, ieee 802.3
    // --------------------
    localparam crc_t CRC_PRESET = 32'hFFFF_FFFF;
    localparam crc_t CRC_POLY   = 32'h04C1_1DB7;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        DATA = 2'd1,
        FIN  = 2'd2
    } rx_state_e;

    // advance over the low n bytes, byte 0 first
    // bits of each byte enter lsb first (reflected input order)
    function automatic crc_t crc_bytes(crc_t crc_in, xgmii_data_t data, int n);
        crc_t crc;
        logic fb;
        crc = crc_in;
        for (int b = 0; b < CTRL_W; b++) begin
            if (b < n) begin
                for (int i = 0; i < 8; i++) begin
                    fb  = crc[31] ^ data[8*b+i];
                    crc = {crc[30:0], 1'b0} ^ (fb ? CRC_POLY : 32'h0);
                end
            end
        end
        return crc;
    endfunction

    // fcs as it shows up on the wire, first byte in bits 7:0
    function automatic crc_t fcs_of(crc_t crc);
        crc_t rev;
        for (int i = 0; i < 32; i++) begin
            rev[i] = crc[31-i];
        end
        return ~rev;
    endfunction

endpackage

// File: xgmii_rx_top.sv
`timescale 1ns/100ps
// --------------------
// 10g xgmii receive adapter, top level
// decode, crc, fsm, output stage, counters
// --------------------
module xgmii_rx_top #(
    parameter int STAT_W = 32
) (
    input  logic                      clk,
    input  logic                      inv_aresetn,
    input  xgmii_rx_pkg::xgmii_data_t xgmii_d_i,
    input  xgmii_rx_pkg::xgmii_ctrl_t xgmii_c_i,
    output xgmii_rx_pkg::xgmii_data_t tdata_o,
    output xgmii_rx_pkg::keep_t       tkeep_o,
    output logic                      tvalid_o,
    output logic                      tlast_o,
    output logic                      tuser_o,
    output logic [STAT_W-1:0]         good_frames_o,
    output logic [STAT_W-1:0]         bad_frames_o
);
    import xgmii_rx_pkg::*;

    // decoder outputs
    logic  sof;
    logic  data_word;
    logic  term;
    lane_t term_lane;
    logic  term_char_ok;
    logic  bad_ctrl;

    // crc strobes and result
    logic  crc_clear;
    logic  crc_advance;
    logic  crc_fin;
    logic  fcs_ok;

    // beat controls
    logic  beat_valid;
    logic  beat_last;
    keep_t beat_keep;
    logic  beat_good;
    logic  beat_hold;

    xgmii_term_decode u_decode (
        .xgmii_d_i      (xgmii_d_i),
        .xgmii_c_i      (xgmii_c_i),
        .sof_o          (sof),
        .data_word_o    (data_word),
        .term_o         (term),
        .term_lane_o    (term_lane),
        .term_char_ok_o (term_char_ok),
        .bad_ctrl_o     (bad_ctrl)
    );

    xgmii_crc_engine u_crc (
        .clk         (clk),
        .inv_aresetn (inv_aresetn),
        .data_i      (xgmii_d_i),
        .clear_i     (crc_clear),
        .advance_i   (crc_advance),
        .term_i      (term),
        .term_lane_i (term_lane),
        .fin_i       (crc_fin),
        .fcs_ok_o    (fcs_ok)
    );

    xgmii_rx_fsm u_fsm (
        .clk            (clk),
        .inv_aresetn    (inv_aresetn),
        .sof_i          (sof),
        .data_word_i    (data_word),
        .term_i         (term),
        .term_lane_i    (term_lane),
        .term_char_ok_i (term_char_ok),
        .bad_ctrl_i     (bad_ctrl),
        .fcs_ok_i       (fcs_ok),
        .crc_clear_o    (crc_clear),
        .crc_advance_o  (crc_advance),
        .crc_fin_o      (crc_fin),
        .beat_valid_o   (beat_valid),
        .beat_last_o    (beat_last),
        .beat_keep_o    (beat_keep),
        .beat_good_o    (beat_good),
        .beat_hold_o    (beat_hold)
    );

    axis_rx_stage u_stage (
        .clk          (clk),
        .inv_aresetn  (inv_aresetn),
        .xgmii_d_i    (xgmii_d_i),
        .beat_hold_i  (beat_hold),
        .beat_valid_i (beat_valid),
        .beat_last_i  (beat_last),
        .beat_keep_i  (beat_keep),
        .beat_good_i  (beat_good),
        .tdata_o      (tdata_o),
        .tkeep_o      (tkeep_o),
        .tvalid_o     (tvalid_o),
        .tlast_o      (tlast_o),
        .tuser_o      (tuser_o)
    );

    rx_frame_counter #(
        .STAT_W (STAT_W)
    ) u_stats (
        .clk           (clk),
        .inv_aresetn   (inv_aresetn),
        .tvalid_i      (tvalid_o),
        .tlast_i       (tlast_o),
        .tuser_i       (tuser_o),
        .good_frames_o (good_frames_o),
        .bad_frames_o  (bad_frames_o)
    );

endmodule

// File: xgmii_term_decode.sv
`timescale 1ns/100ps
// --------------------
// classifies one xgmii word: start, data, terminate
// or an illegal control pattern
// --------------------
module xgmii_term_decode (
    input  xgmii_rx_pkg::xgmii_data_t xgmii_d_i,
    input  xgmii_rx_pkg::xgmii_ctrl_t xgmii_c_i,
    output logic                      sof_o,
    output logic                      data_word_o,
    output logic                      term_o,
    output xgmii_rx_pkg::lane_t       term_lane_o,
    output logic                      term_char_ok_o,
    output logic                      bad_ctrl_o
);
    import xgmii_rx_pkg::*;

    logic [7:0] term_byte;

    // start character on lane 0, preamble and sfd behind it
    assign sof_o = (xgmii_c_i == 8'h01)
                && (xgmii_d_i[7:0] == XGMII_START)
                && (xgmii_d_i[63:8] == PREAMBLE_TAIL);

    assign data_word_o = (xgmii_c_i == '0);

    // --------------------
    // terminate lane
    // --------------------
    // legal masks have every lane from L upwards set
    always_comb begin
        term_o      = 1'b1;
        term_lane_o = 3'd0;
        case (xgmii_c_i)
            8'hFF: term_lane_o = 3'd0;
            8'hFE: term_lane_o = 3'd1;
            8'hFC: term_lane_o = 3'd2;
            8'hF8: term_lane_o = 3'd3;
            8'hF0: term_lane_o = 3'd4;
            8'hE0: term_lane_o = 3'd5;
            8'hC0: term_lane_o = 3'd6;
            8'h80: term_lane_o = 3'd7;
            default: term_o = 1'b0;
        endcase
    end

    // byte sitting in the terminate lane
    assign term_byte = xgmii_d_i[8*term_lane_o +: 8];

    assign term_char_ok_o = term_o && (term_byte == XGMII_TERM);

    // anything that is neither data nor a clean terminate
    assign bad_ctrl_o = !data_word_o && !term_o;

endmodule
